/* hdl/exu_macros.svh */
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// datapath widths
`define EXU_XLEN        32
`define EXU_INST_W      32
`define EXU_REG_ADDR_W  5
`define EXU_SHAMT_W     5   // low bits of op2 used as shift amount

// instruction field positions
`define EXU_OPCODE_LSB  0
`define EXU_OPCODE_MSB  6

`define EXU_RD_LSB      7
`define EXU_RD_MSB      11

`define EXU_FUNCT3_LSB  12
`define EXU_FUNCT3_MSB  14

// bit 30 of the word sits at funct7[5]
`define EXU_FUNCT7_LSB  25
`define EXU_FUNCT7_MSB  31

`endif

/* hdl/exu_pkg.sv */
`default_nettype none

`include "exu_macros.svh"

package exu_pkg;

    // RV32I major opcodes handled by the unit
    typedef enum logic [`EXU_OPCODE_MSB-`EXU_OPCODE_LSB:0] {
        OPC_IMM    = 7'b0010011,
        OPC_REG    = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // write-back operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_AND  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_e;

    // jump conditions, BR_NEVER doubles as the idle value
    typedef enum logic [2:0] {
        BR_NEVER  = 3'd0,
        BR_EQ     = 3'd1,
        BR_NE     = 3'd2,
        BR_LT     = 3'd3,
        BR_GE     = 3'd4,
        BR_LTU    = 3'd5,
        BR_GEU    = 3'd6,
        BR_ALWAYS = 3'd7
    } br_op_e;

endpackage

`default_nettype wire

/* hdl/exu_decode.sv */
`default_nettype none

`include "exu_macros.svh"

module exu_decode (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire                        valid_i,
    input  wire  [`EXU_INST_W-1:0]     inst_i,
    input  wire  [`EXU_XLEN-1:0]       op1_i,
    input  wire  [`EXU_XLEN-1:0]       op2_i,
    input  wire  [`EXU_XLEN-1:0]       jump_base_i,
    input  wire  [`EXU_XLEN-1:0]       jump_offset_i,
    output exu_pkg::alu_op_e           alu_op_o,
    output exu_pkg::br_op_e            br_op_o,
    output logic                       reg_we_o,
    output logic [`EXU_REG_ADDR_W-1:0] rd_o,
    output logic [`EXU_XLEN-1:0]       op1_o,
    output logic [`EXU_XLEN-1:0]       op2_o,
    output logic [`EXU_XLEN-1:0]       jump_base_o,
    output logic [`EXU_XLEN-1:0]       jump_offset_o
);

    exu_pkg::opcode_e                                opcode;
    logic [`EXU_FUNCT3_MSB-`EXU_FUNCT3_LSB:0]        funct3;
    logic [`EXU_FUNCT7_MSB-`EXU_FUNCT7_LSB:0]        funct7;

    exu_pkg::alu_op_e alu_op_n;
    exu_pkg::br_op_e  br_op_n;
    logic             we_n;

    assign opcode = exu_pkg::opcode_e'(inst_i[`EXU_OPCODE_MSB:`EXU_OPCODE_LSB]);
    assign funct3 = inst_i[`EXU_FUNCT3_MSB:`EXU_FUNCT3_LSB];
    assign funct7 = inst_i[`EXU_FUNCT7_MSB:`EXU_FUNCT7_LSB];

    // shared funct3 map for OP and OP-IMM, alt is instruction bit 30
    function automatic exu_pkg::alu_op_e f3_to_alu(
        input logic [2:0] f3,
        input logic       alt,
        input logic       is_reg
    );
        exu_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && alt) ? exu_pkg::ALU_SUB : exu_pkg::ALU_ADD;
            3'b001:  op = exu_pkg::ALU_SLL;
            3'b010:  op = exu_pkg::ALU_SLT;
            3'b011:  op = exu_pkg::ALU_SLTU;
            3'b100:  op = exu_pkg::ALU_XOR;
            3'b101:  op = alt ? exu_pkg::ALU_SRA : exu_pkg::ALU_SRL;
            3'b110:  op = exu_pkg::ALU_OR;
            default: op = exu_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        alu_op_n = exu_pkg::ALU_ADD;
        br_op_n  = exu_pkg::BR_NEVER;
        we_n     = 1'b0;
        case (opcode)
            exu_pkg::OPC_IMM: begin
                alu_op_n = f3_to_alu(funct3, funct7[5], 1'b0);
                we_n     = 1'b1;
            end
            exu_pkg::OPC_REG: begin
                // anything but 0000000 / 0100000 is dropped (M ext etc)
                if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
                    alu_op_n = f3_to_alu(funct3, funct7[5], 1'b1);
                    we_n     = 1'b1;
                end
            end
            exu_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000:  br_op_n = exu_pkg::BR_EQ;
                    3'b001:  br_op_n = exu_pkg::BR_NE;
                    3'b100:  br_op_n = exu_pkg::BR_LT;
                    3'b101:  br_op_n = exu_pkg::BR_GE;
                    3'b110:  br_op_n = exu_pkg::BR_LTU;
                    3'b111:  br_op_n = exu_pkg::BR_GEU;
                    default: br_op_n = exu_pkg::BR_NEVER;   // 010/011 reserved
                endcase
            end
            exu_pkg::OPC_JAL, exu_pkg::OPC_JALR: begin
                we_n    = 1'b1;                 // link value is op1 + op2
                br_op_n = exu_pkg::BR_ALWAYS;
            end
            exu_pkg::OPC_LUI, exu_pkg::OPC_AUIPC: begin
                we_n = 1'b1;
            end
            default: begin
                we_n = 1'b0;
            end
        endcase
    end

    // stage register, control side
    always_ff @(posedge clk) begin
        if (rst_i) begin
            alu_op_o <= exu_pkg::ALU_ADD;
            br_op_o  <= exu_pkg::BR_NEVER;
            reg_we_o <= 1'b0;
        end else begin
            alu_op_o <= alu_op_n;
            br_op_o  <= valid_i ? br_op_n : exu_pkg::BR_NEVER;
            reg_we_o <= valid_i & we_n;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        rd_o          <= inst_i[`EXU_RD_MSB:`EXU_RD_LSB];
        op1_o         <= op1_i;
        op2_o         <= op2_i;
        jump_base_o   <= jump_base_i;
        jump_offset_o <= jump_offset_i;
    end

endmodule

`default_nettype wire

/* hdl/exu_alu.sv */
`default_nettype none

`include "exu_macros.svh"

module exu_alu (
    input  wire                        clk,
    input  wire                        rst_i,
    input  exu_pkg::alu_op_e           alu_op_i,
    input  wire                        reg_we_i,
    input  wire  [`EXU_REG_ADDR_W-1:0] rd_i,
    input  wire  [`EXU_XLEN-1:0]       op1_i,
    input  wire  [`EXU_XLEN-1:0]       op2_i,
    output logic                       reg_we_o,
    output logic [`EXU_REG_ADDR_W-1:0] reg_waddr_o,
    output logic [`EXU_XLEN-1:0]       reg_wdata_o
);

    logic [`EXU_SHAMT_W-1:0] shamt;
    logic                    lt_s;
    logic                    lt_u;
    logic [`EXU_XLEN-1:0]    result;

    assign shamt = op2_i[`EXU_SHAMT_W-1:0];     // imm or rs2, decoder already chose
    assign lt_s  = $signed(op1_i) < $signed(op2_i);
    assign lt_u  = op1_i < op2_i;

    always_comb begin
        case (alu_op_i)
            exu_pkg::ALU_ADD:  result = op1_i + op2_i;
            exu_pkg::ALU_SUB:  result = op1_i - op2_i;
            exu_pkg::ALU_SLT:  result = {{(`EXU_XLEN-1){1'b0}}, lt_s};
            exu_pkg::ALU_SLTU: result = {{(`EXU_XLEN-1){1'b0}}, lt_u};
            exu_pkg::ALU_XOR:  result = op1_i ^ op2_i;
            exu_pkg::ALU_OR:   result = op1_i | op2_i;
            exu_pkg::ALU_AND:  result = op1_i & op2_i;
            exu_pkg::ALU_SLL:  result = op1_i << shamt;
            exu_pkg::ALU_SRL:  result = op1_i >> shamt;
            exu_pkg::ALU_SRA:  result = $unsigned($signed(op1_i) >>> shamt);
            default:           result = '0;
        endcase
    end

    // write-back register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            reg_we_o    <= 1'b0;
            reg_waddr_o <= '0;
            reg_wdata_o <= '0;
        end else begin
            reg_we_o    <= reg_we_i;
            // idle cycles keep address and data at zero
            reg_waddr_o <= reg_we_i ? rd_i : '0;
            reg_wdata_o <= reg_we_i ? result : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/exu_branch.sv */
`default_nettype none

`include "exu_macros.svh"

module exu_branch (
    input  wire                  clk,
    input  wire                  rst_i,
    input  exu_pkg::br_op_e      br_op_i,
    input  wire  [`EXU_XLEN-1:0] op1_i,
    input  wire  [`EXU_XLEN-1:0] op2_i,
    input  wire  [`EXU_XLEN-1:0] jump_base_i,
    input  wire  [`EXU_XLEN-1:0] jump_offset_i,
    output logic                 jump_flag_o,
    output logic [`EXU_XLEN-1:0] jump_addr_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic taken;

    assign eq   = op1_i == op2_i;
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        case (br_op_i)
            exu_pkg::BR_EQ:     taken = eq;
            exu_pkg::BR_NE:     taken = ~eq;
            exu_pkg::BR_LT:     taken = lt_s;
            exu_pkg::BR_GE:     taken = ~lt_s;
            exu_pkg::BR_LTU:    taken = lt_u;
            exu_pkg::BR_GEU:    taken = ~lt_u;
            exu_pkg::BR_ALWAYS: taken = 1'b1;   // jal / jalr
            default:            taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            jump_flag_o <= 1'b0;
            jump_addr_o <= '0;
        end else begin
            jump_flag_o <= taken;
            jump_addr_o <= taken ? jump_base_i + jump_offset_i : '0;  // zero when not taken
        end
    end

endmodule

`default_nettype wire

/* hdl/exu_top.sv */
`default_nettype none

`include "exu_macros.svh"

module exu_top (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire                        valid_i,
    input  wire  [`EXU_INST_W-1:0]     inst_i,
    input  wire  [`EXU_XLEN-1:0]       op1_i,
    input  wire  [`EXU_XLEN-1:0]       op2_i,
    input  wire  [`EXU_XLEN-1:0]       jump_base_i,
    input  wire  [`EXU_XLEN-1:0]       jump_offset_i,
    output logic                       reg_we_o,
    output logic [`EXU_REG_ADDR_W-1:0] reg_waddr_o,
    output logic [`EXU_XLEN-1:0]       reg_wdata_o,
    output logic                       jump_flag_o,
    output logic [`EXU_XLEN-1:0]       jump_addr_o
);

    // stage one outputs
    exu_pkg::alu_op_e           alu_op;
    exu_pkg::br_op_e            br_op;
    logic                       reg_we;
    logic [`EXU_REG_ADDR_W-1:0] rd;
    logic [`EXU_XLEN-1:0]       op1;
    logic [`EXU_XLEN-1:0]       op2;
    logic [`EXU_XLEN-1:0]       jump_base;
    logic [`EXU_XLEN-1:0]       jump_offset;

    exu_decode i_exu_decode (
        .clk           (clk),
        .rst_i         (rst_i),
        .valid_i       (valid_i),
        .inst_i        (inst_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .jump_base_i   (jump_base_i),
        .jump_offset_i (jump_offset_i),
        .alu_op_o      (alu_op),
        .br_op_o       (br_op),
        .reg_we_o      (reg_we),
        .rd_o          (rd),
        .op1_o         (op1),
        .op2_o         (op2),
        .jump_base_o   (jump_base),
        .jump_offset_o (jump_offset)
    );

    exu_alu i_exu_alu (
        .clk         (clk),
        .rst_i       (rst_i),
        .alu_op_i    (alu_op),
        .reg_we_i    (reg_we),
        .rd_i        (rd),
        .op1_i       (op1),
        .op2_i       (op2),
        .reg_we_o    (reg_we_o),
        .reg_waddr_o (reg_waddr_o),
        .reg_wdata_o (reg_wdata_o)
    );

    exu_branch i_exu_branch (
        .clk           (clk),
        .rst_i         (rst_i),
        .br_op_i       (br_op),
        .op1_i         (op1),
        .op2_i         (op2),
        .jump_base_i   (jump_base),
        .jump_offset_i (jump_offset),
        .jump_flag_o   (jump_flag_o),
        .jump_addr_o   (jump_addr_o)
    );

endmodule

`default_nettype wire

/* testbench/exu_assert.sv */
`default_nettype none

`include "exu_macros.svh"

module exu_assert (
    input wire                 clk,
    input wire                 rst_i,
    input wire                 valid_i,
    input wire                 reg_we_o,
    input wire                 jump_flag_o,
    input wire [`EXU_XLEN-1:0] jump_addr_o
);

    // target only while jumping
    a_addr_idle: assert property (
        @(posedge clk) disable iff (rst_i)
        !jump_flag_o |-> jump_addr_o == '0
    ) else $error("jump_addr_o nonzero while jump_flag_o is low");

    // two stage latency, an idle input cycle gives idle outputs
    a_idle_out: assert property (
        @(posedge clk) disable iff (rst_i)
        !valid_i |-> ##2 (!reg_we_o && !jump_flag_o)
    ) else $error("write or jump two cycles after valid_i low");

    a_reset_out: assert property (
        @(posedge clk)
        rst_i |=> (!reg_we_o && !jump_flag_o)
    ) else $error("outputs active right after reset");

endmodule

bind exu_top exu_assert i_exu_assert (
    .clk         (clk),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .reg_we_o    (reg_we_o),
    .jump_flag_o (jump_flag_o),
    .jump_addr_o (jump_addr_o)
);

`default_nettype wire

/* testbench/exu_tb.sv */
`default_nettype none

`include "exu_macros.svh"

module exu_tb;

    localparam int PERIOD   = 4;
    localparam int RST_CYC  = 16;
    localparam int REPS     = 4;
    localparam int N_RESET  = 4;
    localparam int N_ALU    = 19 * REPS + 8;
    localparam int N_SHIFT  = 6 * REPS;
    localparam int N_BRANCH = 12;
    localparam int N_UNCOND = 4 * 3;
    localparam int N_STREAM = 24;
    localparam int N_TOTAL  = N_RESET + N_ALU + N_SHIFT + N_BRANCH + N_UNCOND + N_STREAM;
    localparam int WATCHDOG = (N_TOTAL + RST_CYC + 100) * PERIOD;

    // one issued instruction with its expected outputs
    typedef struct packed {
        logic                       valid;
        logic [`EXU_INST_W-1:0]     inst;
        logic [`EXU_XLEN-1:0]       op1;
        logic [`EXU_XLEN-1:0]       op2;
        logic [`EXU_XLEN-1:0]       base;
        logic [`EXU_XLEN-1:0]       off;
        logic                       exp_we;
        logic [`EXU_REG_ADDR_W-1:0] exp_rd;
        logic [`EXU_XLEN-1:0]       exp_wdata;
        logic                       exp_jf;
        logic [`EXU_XLEN-1:0]       exp_ja;
    } item_t;

    logic                       clk = 1'b0;
    logic                       rst_i;
    logic                       valid_i;
    logic [`EXU_INST_W-1:0]     inst_i;
    logic [`EXU_XLEN-1:0]       op1_i;
    logic [`EXU_XLEN-1:0]       op2_i;
    logic [`EXU_XLEN-1:0]       jump_base_i;
    logic [`EXU_XLEN-1:0]       jump_offset_i;
    logic                       reg_we_o;
    logic [`EXU_REG_ADDR_W-1:0] reg_waddr_o;
    logic [`EXU_XLEN-1:0]       reg_wdata_o;
    logic                       jump_flag_o;
    logic [`EXU_XLEN-1:0]       jump_addr_o;

    logic [31:0] rng_state = 32'h7de8;
    int          error_count = 0;
    int          check_count = 0;
    item_t       items[$];

    always #(PERIOD / 2) clk = ~clk;

    exu_top i_exu_top (
        .clk           (clk),
        .rst_i         (rst_i),
        .valid_i       (valid_i),
        .inst_i        (inst_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .jump_base_i   (jump_base_i),
        .jump_offset_i (jump_offset_i),
        .reg_we_o      (reg_we_o),
        .reg_waddr_o   (reg_waddr_o),
        .reg_wdata_o   (reg_wdata_o),
        .jump_flag_o   (jump_flag_o),
        .jump_addr_o   (jump_addr_o)
    );

    function logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic less_signed(logic [31:0] a, logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);  // differing signs decide alone
    endfunction

    // RV32I OP / OP-IMM result where alt picks SUB or SRA
    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] r;
        sh = b[4:0];
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << sh;
            3'b010:  r = {31'd0, less_signed(a, b)};
            3'b011:  r = {31'd0, a < b};
            3'b100:  r = a ^ b;
            3'b101: begin
                r = a >> sh;
                if (alt && a[31])
                    r = r | ~(32'hffff_ffff >> sh);  // sign fill
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic item_t expect_item(item_t it);
        item_t      e;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       taken;
        e     = it;
        opc   = it.inst[6:0];
        f3    = it.inst[14:12];
        f7    = it.inst[31:25];
        taken = 1'b0;
        e.exp_we    = 1'b0;
        e.exp_wdata = '0;
        if (it.valid) begin
            case (opc)
                7'b0010011: begin
                    e.exp_we    = 1'b1;
                    e.exp_wdata = alu_ref(f3, (f3 == 3'b101) && f7[5], it.op1, it.op2);
                end
                7'b0110011: begin
                    if (f7 == 7'h00 || f7 == 7'h20) begin
                        e.exp_we    = 1'b1;
                        e.exp_wdata = alu_ref(f3, f7[5], it.op1, it.op2);
                    end
                end
                7'b1100011: begin
                    case (f3)
                        3'b000:  taken = it.op1 == it.op2;
                        3'b001:  taken = it.op1 != it.op2;
                        3'b100:  taken = less_signed(it.op1, it.op2);
                        3'b101:  taken = !less_signed(it.op1, it.op2);
                        3'b110:  taken = it.op1 < it.op2;
                        3'b111:  taken = it.op1 >= it.op2;
                        default: taken = 1'b0;
                    endcase
                end
                7'b1101111, 7'b1100111: begin
                    e.exp_we    = 1'b1;
                    e.exp_wdata = it.op1 + it.op2;
                    taken       = 1'b1;
                end
                7'b0110111, 7'b0010111: begin
                    e.exp_we    = 1'b1;
                    e.exp_wdata = it.op1 + it.op2;
                end
                default: ;
            endcase
        end
        e.exp_rd = e.exp_we ? it.inst[11:7] : 5'd0;
        e.exp_jf = taken;
        e.exp_ja = taken ? it.base + it.off : '0;
        return e;
    endfunction

    // random rd and rs fields around the given opcode fields
    function automatic logic [31:0] encode(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc);
        logic [31:0] r;
        r = xorshift32();
        return {f7, r[14:5], f3, r[4:0], opc};
    endfunction

    task automatic add_item(logic valid, logic [31:0] inst, logic [31:0] a, logic [31:0] b);
        item_t it;
        it       = '0;
        it.valid = valid;
        it.inst  = inst;
        it.op1   = a;
        it.op2   = b;
        it.base  = xorshift32();
        it.off   = xorshift32();
        items.push_back(expect_item(it));
    endtask

    task automatic check_value(string name, string field, logic [31:0] exp, logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("mismatch %s %s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    task automatic check_item(string name, item_t it);
        check_value(name, "reg_we", 32'(it.exp_we), 32'(reg_we_o));
        if (it.exp_we) begin
            check_value(name, "reg_waddr", 32'(it.exp_rd), 32'(reg_waddr_o));
            check_value(name, "reg_wdata", it.exp_wdata, reg_wdata_o);
        end
        check_value(name, "jump_flag", 32'(it.exp_jf), 32'(jump_flag_o));
        check_value(name, "jump_addr", it.exp_ja, jump_addr_o);
    endtask

    // issue back to back and check each result two cycles later
    task automatic run_stream(string name);
        int n;
        n = items.size();
        for (int c = 0; c < n + 2; c++) begin
            @(posedge clk);
            if (c < n) begin
                valid_i       <= items[c].valid;
                inst_i        <= items[c].inst;
                op1_i         <= items[c].op1;
                op2_i         <= items[c].op2;
                jump_base_i   <= items[c].base;
                jump_offset_i <= items[c].off;
            end else begin
                valid_i <= 1'b0;
            end
            @(negedge clk);
            if (c >= 2)
                check_item(name, items[c - 2]);
        end
        items.delete();
    endtask

    task automatic test_reset();
        for (int c = 0; c < N_RESET; c++) begin
            @(posedge clk);
            valid_i       <= 1'b0;
            inst_i        <= encode(7'h00, 3'b000, 7'h6f);  // jal that must be ignored
            op1_i         <= xorshift32();
            op2_i         <= xorshift32();
            jump_base_i   <= xorshift32();
            jump_offset_i <= xorshift32();
            @(negedge clk);
            check_value("reset", "reg_we", 32'd0, 32'(reg_we_o));
            check_value("reset", "reg_waddr", 32'd0, 32'(reg_waddr_o));
            check_value("reset", "reg_wdata", 32'd0, reg_wdata_o);
            check_value("reset", "jump_flag", 32'd0, 32'(jump_flag_o));
            check_value("reset", "jump_addr", 32'd0, jump_addr_o);
        end
    endtask

    task automatic test_alu_ops();
        logic [6:0]  f7_imm;
        logic [31:0] pos;
        logic [31:0] neg;
        for (int k = 0; k < REPS; k++) begin
            for (int f = 0; f < 8; f++) begin
                f7_imm = (f == 1 || f == 5) ? 7'h00 : 7'(xorshift32() >> 25);
                add_item(1'b1, encode(f7_imm, 3'(f), 7'h13), xorshift32(), xorshift32());
                add_item(1'b1, encode(7'h00, 3'(f), 7'h33), xorshift32(), xorshift32());
            end
            add_item(1'b1, encode(7'h20, 3'b101, 7'h13), xorshift32(), xorshift32()); // srai
            add_item(1'b1, encode(7'h20, 3'b000, 7'h33), xorshift32(), xorshift32()); // sub
            add_item(1'b1, encode(7'h20, 3'b101, 7'h33), xorshift32(), xorshift32()); // sra
        end
        // slt / sltu with operand signs that differ
        for (int f = 2; f < 4; f++) begin
            pos = xorshift32() & 32'h7fff_ffff;
            neg = xorshift32() | 32'h8000_0000;
            add_item(1'b1, encode(7'h00, 3'(f), 7'h13), pos, neg);
            add_item(1'b1, encode(7'h00, 3'(f), 7'h13), neg, pos);
            add_item(1'b1, encode(7'h00, 3'(f), 7'h33), pos, neg);
            add_item(1'b1, encode(7'h00, 3'(f), 7'h33), neg, pos);
        end
        run_stream("alu_ops");
    endtask

    task automatic test_shifts();
        logic [6:0] opc;
        for (int k = 0; k < REPS; k++) begin
            for (int s = 0; s < 2; s++) begin
                opc = (s == 0) ? 7'h13 : 7'h33;
                add_item(1'b1, encode(7'h00, 3'b001, opc),
                         xorshift32() | 32'h8000_0000, xorshift32());
                add_item(1'b1, encode(7'h00, 3'b101, opc),
                         xorshift32() | 32'h8000_0000, xorshift32());
                add_item(1'b1, encode(7'h20, 3'b101, opc),
                         xorshift32() | 32'h8000_0000, xorshift32());
            end
        end
        run_stream("shifts");
    endtask

    task automatic test_branches();
        logic [2:0]  conds [6];
        logic [31:0] a;
        logic [31:0] b;
        conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int i = 0; i < 6; i++) begin
            a = xorshift32() & 32'h7fff_ffff;   // positive
            b = xorshift32() | 32'h8000_0000;   // negative but larger unsigned
            if (conds[i][2]) begin
                add_item(1'b1, encode(7'(xorshift32() >> 25), conds[i], 7'h63), a, b);
                add_item(1'b1, encode(7'(xorshift32() >> 25), conds[i], 7'h63), b, a);
            end else begin
                add_item(1'b1, encode(7'(xorshift32() >> 25), conds[i], 7'h63), a, a);
                add_item(1'b1, encode(7'(xorshift32() >> 25), conds[i], 7'h63), a, b);
            end
        end
        run_stream("branches");
    endtask

    task automatic test_uncond();
        for (int k = 0; k < 3; k++) begin
            add_item(1'b1, encode(7'(xorshift32() >> 25), 3'b000, 7'h6f), xorshift32(), 32'd4);
            add_item(1'b1, encode(7'(xorshift32() >> 25), 3'b000, 7'h67), xorshift32(), 32'd4);
            add_item(1'b1, encode(7'(xorshift32() >> 25), 3'b000, 7'h37), 32'd0, xorshift32());
            add_item(1'b1, encode(7'(xorshift32() >> 25), 3'b000, 7'h17), xorshift32(),
                     xorshift32());
        end
        run_stream("uncond");
    endtask

    // valid mix with dropped encodings and idle slots
    task automatic test_stream();
        for (int i = 0; i < N_STREAM; i++) begin
            case (i % 6)
                0: add_item(1'b1, encode(7'h00, 3'b000, 7'h33), xorshift32(), xorshift32());
                1: add_item(1'b1, encode(7'h01, 3'(i), 7'h33), xorshift32(), xorshift32());
                2: add_item(1'b1, encode(7'h00, 3'b010, 7'h03), xorshift32(), xorshift32());
                3: add_item(1'b1, encode(7'h00, 3'b001, 7'h73), xorshift32(), xorshift32());
                4: add_item(1'b1, encode(7'h00, 3'b001, 7'h63), xorshift32(), xorshift32());
                default: add_item(1'b0, encode(7'h00, 3'b000, 7'h13), xorshift32(),
                                  xorshift32());
            endcase
        end
        run_stream("stream");
    endtask

    initial begin
        #(WATCHDOG);
        $display("watchdog timeout, simulation did not finish in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        rst_i         = 1'b1;
        valid_i       = 1'b0;
        inst_i        = '0;
        op1_i         = '0;
        op2_i         = '0;
        jump_base_i   = '0;
        jump_offset_i = '0;
        repeat (RST_CYC) @(posedge clk);
        rst_i <= 1'b0;

        test_reset();
        test_alu_ops();
        test_shifts();
        test_branches();
        test_uncond();
        test_stream();

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/exu_pkg.sv
hdl/exu_decode.sv
hdl/exu_alu.sv
hdl/exu_branch.sv
hdl/exu_top.sv
testbench/exu_assert.sv
testbench/exu_tb.sv

/* Makefile */
# Verilator build and run of the execute unit testbench

VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
